//--- tape_pkg.sv
// Tape-side types for the tape deck: data bytes, Wishbone buses and the decoder port
package tape_pkg;

	// ==================================================
	// Constants
	// ==================================================

	// Full Wishbone address width, the store decodes only the low bits
	localparam int WB_ADR_W = 24;
	localparam int BYTE_W   = 8;

	// ==================================================
	// Data and bus types
	// ==================================================

	typedef logic [BYTE_W-1:0] tape_byte_t;

	// Wishbone classic master request
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [WB_ADR_W-1:0] adr;
		tape_byte_t          dat;
	} wb_req_t;

	// Wishbone classic slave response
	typedef struct packed {
		logic       ack;
		tape_byte_t dat;
	} wb_rsp_t;

	// Commands from the external tape decoder
	typedef struct packed {
		logic req;         // byte request toggle
		logic loop_start;
		logic loop_next;
		logic stop;        // plain stop and 48K stop merged
	} dec_cmd_t;

	// Answer to the decoder, the ack toggle qualifies dat
	typedef struct packed {
		logic       ack;
		tape_byte_t dat;
	} dec_rsp_t;

endpackage

//--- host_pkg.sv
// Host-side types for the tape deck: image download writes and keyboard events
package host_pkg;

	// ==================================================
	// Download port
	// ==================================================

	// One byte of the tape image coming from the host
	typedef struct packed {
		logic        downloading;
		logic        wr;
		logic [23:0] addr;
		logic [7:0]  dat;
	} dl_write_t;

	// ==================================================
	// Keyboard
	// ==================================================

	// A new event is signalled by a change of toggle
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} key_event_t;

	// Scan codes of the function keys used by the deck
	localparam logic [8:0] KEY_PLAY   = 9'h003;  // F5
	localparam logic [8:0] KEY_REWIND = 9'h00B;  // F6
	localparam logic [8:0] KEY_EJECT  = 9'h083;  // F7

endpackage

//--- tape_loader.sv
// Tape loader: turns host download writes into Wishbone writes and records the tape length
`timescale 1ns/1ps

module tape_loader #(
	parameter int ADDR_W = 12
) (
	input  logic                clk_sys,
	input  logic                RESET,
	input  host_pkg::dl_write_t dl_i,
	output logic                wait_o,
	output tape_pkg::wb_req_t   wb_o,
	input  tape_pkg::wb_rsp_t   wb_i,
	output logic [ADDR_W:0]     tape_len_o,
	output logic                loaded_o
);

	logic                             wr_cyc_q;
	logic [tape_pkg::WB_ADR_W-1:0]    wr_adr_q;
	tape_pkg::tape_byte_t             wr_dat_q;
	logic [ADDR_W-1:0]                last_adr_q;
	logic                             dl_q;
	logic                             dl_end;

	// Falling edge of the downloading flag
	assign dl_end = dl_q & ~dl_i.downloading;

	// Host must hold off while a write is on the bus
	assign wait_o = wr_cyc_q;

	always_comb begin
		wb_o.cyc = wr_cyc_q;
		wb_o.stb = wr_cyc_q;
		wb_o.we  = 1'b1;
		wb_o.adr = wr_adr_q;
		wb_o.dat = wr_dat_q;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			wr_cyc_q   <= 1'b0;
			dl_q       <= 1'b0;
			loaded_o   <= 1'b0;
			tape_len_o <= '0;
		end else begin
			dl_q     <= dl_i.downloading;
			loaded_o <= dl_end;
			if (dl_i.wr)
				wr_cyc_q <= 1'b1;
			else if (wb_i.ack)
				wr_cyc_q <= 1'b0;
			// Length is one past the last byte written
			if (dl_end)
				tape_len_o <= {1'b0, last_adr_q} + 1'b1;
		end
	end

	// Write payload, captured with the host strobe
	always_ff @(posedge clk_sys) begin
		if (dl_i.wr) begin
			wr_adr_q   <= dl_i.addr;
			wr_dat_q   <= dl_i.dat;
			last_adr_q <= dl_i.addr[ADDR_W-1:0];
		end
	end

endmodule

//--- tape_player.sv
// Tape player: playback state, key control, loop marks and byte reads for the decoder
`timescale 1ns/1ps

module tape_player #(
	parameter int ADDR_W = 12
) (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  host_pkg::key_event_t key_i,
	input  tape_pkg::dec_cmd_t   dec_i,
	output tape_pkg::dec_rsp_t   dec_o,
	input  logic [ADDR_W:0]      tape_len_i,
	input  logic                 loaded_i,
	output tape_pkg::wb_req_t    wb_o,
	input  tape_pkg::wb_rsp_t    wb_i,
	output logic                 playing_o,
	output logic                 ready_o
);

	logic                 key_tgl_q;
	logic                 key_evt;
	logic                 ready_q;
	logic                 playing_q;
	logic [ADDR_W-1:0]    addr_q;      // next byte to serve
	logic [ADDR_W-1:0]    loop_q;
	logic                 rd_cyc_q;
	logic [ADDR_W-1:0]    rd_adr_q;
	logic                 ack_q;
	tape_pkg::tape_byte_t dat_q;
	logic                 rd_start;
	logic [ADDR_W:0]      rd_pos;
	logic                 rd_last;

	assign key_evt  = key_i.toggle ^ key_tgl_q;
	// Open request when the toggles differ and nothing is in flight
	assign rd_start = ~rd_cyc_q & (dec_i.req ^ ack_q);
	assign rd_pos   = {1'b0, rd_adr_q} + 1'b1;
	assign rd_last  = wb_i.ack & (rd_pos >= tape_len_i);

	assign playing_o = playing_q;
	assign ready_o   = ready_q;

	always_comb begin
		dec_o.ack = ack_q;
		dec_o.dat = dat_q;
		wb_o.cyc  = rd_cyc_q;
		wb_o.stb  = rd_cyc_q;
		wb_o.we   = 1'b0;
		wb_o.adr  = {{(tape_pkg::WB_ADR_W-ADDR_W){1'b0}}, rd_adr_q};
		wb_o.dat  = '0;
	end

	// ==================================================
	// Playback state and address counter
	// ==================================================

	always_ff @(posedge clk_sys) begin
		key_tgl_q <= key_i.toggle;
		if (RESET) begin
			ready_q   <= 1'b0;
			playing_q <= 1'b0;
			addr_q    <= '0;
			loop_q    <= '0;
		end else begin
			// Address advances as each read is issued
			if (rd_start)
				addr_q <= addr_q + 1'b1;
			if (dec_i.loop_start)
				loop_q <= addr_q;
			if (dec_i.loop_next)
				addr_q <= loop_q;

			if (key_evt) begin
				if (key_i.code == host_pkg::KEY_PLAY && key_i.pressed)
					playing_q <= ~playing_q;
				if (key_i.code == host_pkg::KEY_REWIND) begin
					addr_q    <= '0;
					playing_q <= 1'b0;
				end
				if (key_i.code == host_pkg::KEY_EJECT) begin
					ready_q   <= 1'b0;
					playing_q <= 1'b0;
				end
			end

			if (dec_i.stop)
				playing_q <= 1'b0;
			// Last byte of the tape delivered
			if (rd_last) begin
				ready_q   <= 1'b0;
				playing_q <= 1'b0;
			end
			if (!ready_q)
				playing_q <= 1'b0;

			// A fresh image overrides everything
			if (loaded_i) begin
				ready_q   <= 1'b1;
				playing_q <= 1'b1;
				addr_q    <= '0;
			end
		end
	end

	// ==================================================
	// Wishbone read and decoder handshake
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rd_cyc_q <= 1'b0;
			ack_q    <= 1'b0;
		end else begin
			if (rd_start)
				rd_cyc_q <= 1'b1;
			else if (wb_i.ack)
				rd_cyc_q <= 1'b0;
			if (wb_i.ack)
				ack_q <= ~ack_q;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd_start)
			rd_adr_q <= addr_q;
		if (wb_i.ack)
			dat_q <= wb_i.dat;
	end

endmodule

//--- tape_store.sv
// Tape store: two-master Wishbone arbiter with loader priority in front of the tape RAM
`timescale 1ns/1ps

module tape_store #(
	parameter int ADDR_W = 12
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  tape_pkg::wb_req_t ld_req_i,
	input  tape_pkg::wb_req_t pl_req_i,
	output tape_pkg::wb_rsp_t ld_rsp_o,
	output tape_pkg::wb_rsp_t pl_rsp_o
);

	typedef enum logic [1:0] {
		GNT_NONE,
		GNT_LD,
		GNT_PL
	} gnt_e;

	gnt_e                 gnt_q;
	logic                 done_q;      // access of this grant already made
	logic                 ack_ld_q;
	logic                 ack_pl_q;
	tape_pkg::wb_req_t    sel;
	logic                 access;
	logic [ADDR_W-1:0]    mem_adr;
	tape_pkg::tape_byte_t rd_q;
	tape_pkg::tape_byte_t mem [2**ADDR_W];

	assign sel     = (gnt_q == GNT_LD) ? ld_req_i : pl_req_i;
	assign access  = (gnt_q != GNT_NONE) & sel.cyc & sel.stb & ~done_q;
	assign mem_adr = sel.adr[ADDR_W-1:0];

	// Read data only goes to the master being acked
	always_comb begin
		ld_rsp_o.ack = ack_ld_q;
		ld_rsp_o.dat = ack_ld_q ? rd_q : '0;
		pl_rsp_o.ack = ack_pl_q;
		pl_rsp_o.dat = ack_pl_q ? rd_q : '0;
	end

	// ==================================================
	// Arbiter
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			gnt_q    <= GNT_NONE;
			done_q   <= 1'b0;
			ack_ld_q <= 1'b0;
			ack_pl_q <= 1'b0;
		end else begin
			ack_ld_q <= access & (gnt_q == GNT_LD);
			ack_pl_q <= access & (gnt_q == GNT_PL);
			if (access)
				done_q <= 1'b1;
			case (gnt_q)
				GNT_NONE: begin
					done_q <= 1'b0;
					if (ld_req_i.cyc && ld_req_i.stb)
						gnt_q <= GNT_LD;
					else if (pl_req_i.cyc && pl_req_i.stb)
						gnt_q <= GNT_PL;
				end
				// Grant held until the owner drops cyc
				default: begin
					if (!sel.cyc)
						gnt_q <= GNT_NONE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (access) begin
			if (sel.we)
				mem[mem_adr] <= sel.dat;
			rd_q <= mem[mem_adr];
		end
	end

endmodule

//--- tape_activity_led.sv
// Tape activity LED: slowly swelling pulse while playing, steady when paused with a tape
`timescale 1ns/1ps

module tape_activity_led #(
	parameter int LED_W = 23
) (
	input  logic clk_sys,
	input  logic RESET,
	input  logic playing_i,
	input  logic ready_i,
	output logic led_o
);

	logic [LED_W-1:0] cnt_q;
	logic [7:0]       sweep;
	logic [7:0]       phase;
	logic             run;

	// Upper slice sets the duty, low byte is the PWM phase
	assign sweep = cnt_q[LED_W-2 -: 8];
	assign phase = cnt_q[7:0];

	// Keep running until the top bit settles on ready
	assign run = playing_i | (cnt_q[LED_W-1] ^ ready_i) | (|cnt_q[LED_W-2:0]);

	always_ff @(posedge clk_sys) begin
		if (RESET)
			cnt_q <= '0;
		else if (run)
			cnt_q <= cnt_q + 1'b1;
	end

	// Rising duty in the lower half, falling in the upper half
	assign led_o = cnt_q[LED_W-1] ? (sweep <= phase) : (sweep > phase);

endmodule

//--- tape_deck_top.sv
// Tape deck top level: loader, player, tape store and activity LED
`timescale 1ns/1ps

module tape_deck_top #(
	parameter int ADDR_W = 12,
	parameter int LED_W  = 23
) (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  host_pkg::dl_write_t  dl_i,
	output logic                 wait_o,
	input  host_pkg::key_event_t key_i,
	input  tape_pkg::dec_cmd_t   dec_i,
	output tape_pkg::dec_rsp_t   dec_o,
	output logic                 playing_o,
	output logic                 ready_o,
	output logic                 led_o
);

	tape_pkg::wb_req_t wb_ld_req;
	tape_pkg::wb_req_t wb_pl_req;
	tape_pkg::wb_rsp_t wb_ld_rsp;
	tape_pkg::wb_rsp_t wb_pl_rsp;
	logic [ADDR_W:0]   tape_len;
	logic              loaded;

	tape_loader #(.ADDR_W(ADDR_W)) u_tape_loader (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl_i       (dl_i),
		.wait_o     (wait_o),
		.wb_o       (wb_ld_req),
		.wb_i       (wb_ld_rsp),
		.tape_len_o (tape_len),
		.loaded_o   (loaded)
	);

	tape_player #(.ADDR_W(ADDR_W)) u_tape_player (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.key_i      (key_i),
		.dec_i      (dec_i),
		.dec_o      (dec_o),
		.tape_len_i (tape_len),
		.loaded_i   (loaded),
		.wb_o       (wb_pl_req),
		.wb_i       (wb_pl_rsp),
		.playing_o  (playing_o),
		.ready_o    (ready_o)
	);

	tape_store #(.ADDR_W(ADDR_W)) u_tape_store (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.ld_req_i (wb_ld_req),
		.pl_req_i (wb_pl_req),
		.ld_rsp_o (wb_ld_rsp),
		.pl_rsp_o (wb_pl_rsp)
	);

	tape_activity_led #(.LED_W(LED_W)) u_tape_activity_led (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.playing_i (playing_o),
		.ready_i   (ready_o),
		.led_o     (led_o)
	);

endmodule

//--- tape_deck_assertions.sv
// Tape deck checker: bound concurrent assertions on data, handshakes and status
`timescale 1ns/1ps

module tape_deck_assertions #(
	parameter int ADDR_W = 12
) (
	input logic                 clk_sys,
	input logic                 RESET,
	input host_pkg::dl_write_t  dl_i,
	input logic                 wait_o,
	input tape_pkg::wb_req_t    ld_req,
	input tape_pkg::wb_rsp_t    ld_rsp,
	input tape_pkg::wb_req_t    pl_req,
	input tape_pkg::wb_rsp_t    pl_rsp,
	input tape_pkg::dec_rsp_t   dec_o,
	input logic                 playing_o,
	input logic                 ready_o
);

	int                   fail_cnt = 0;
	tape_pkg::tape_byte_t shadow [2**ADDR_W];
	tape_pkg::tape_byte_t exp_q;

	// Shadow of every byte written, and the byte expected by the decoder
	always_ff @(posedge clk_sys) begin
		if (ld_rsp.ack && ld_req.we)
			shadow[ld_req.adr[ADDR_W-1:0]] <= ld_req.dat;
		if (pl_rsp.ack)
			exp_q <= shadow[pl_req.adr[ADDR_W-1:0]];
	end

	// ==================================================
	// Host side
	// ==================================================

	a_wait_rise: assert property (@(posedge clk_sys) disable iff (RESET)
		dl_i.wr |=> wait_o)
		else begin fail_cnt++; $error("wait_o did not rise after a write strobe"); end

	a_host_hold: assert property (@(posedge clk_sys) disable iff (RESET)
		dl_i.wr |-> !wait_o)
		else begin fail_cnt++; $error("host wrote while wait_o was high"); end

	// ==================================================
	// Wishbone
	// ==================================================

	a_ld_stable: assert property (@(posedge clk_sys) disable iff (RESET)
		ld_req.stb && !ld_rsp.ack |=> ld_req.stb && $stable(ld_req.adr) && $stable(ld_req.dat))
		else begin fail_cnt++; $error("loader request changed before ack"); end

	a_pl_stable: assert property (@(posedge clk_sys) disable iff (RESET)
		pl_req.stb && !pl_rsp.ack |=> pl_req.stb && $stable(pl_req.adr))
		else begin fail_cnt++; $error("player request changed before ack"); end

	a_ld_ack: assert property (@(posedge clk_sys) disable iff (RESET)
		ld_rsp.ack |-> ld_req.stb ##1 !ld_rsp.ack)
		else begin fail_cnt++; $error("loader ack without stb or longer than one cycle"); end

	a_pl_ack: assert property (@(posedge clk_sys) disable iff (RESET)
		pl_rsp.ack |-> pl_req.stb ##1 !pl_rsp.ack)
		else begin fail_cnt++; $error("player ack without stb or longer than one cycle"); end

	a_ack_excl: assert property (@(posedge clk_sys) disable iff (RESET)
		!(ld_rsp.ack && pl_rsp.ack))
		else begin fail_cnt++; $error("both masters acked together"); end

	// ==================================================
	// Decoder port and status
	// ==================================================

	a_dec_data: assert property (@(posedge clk_sys) disable iff (RESET)
		$changed(dec_o.ack) |-> dec_o.dat == exp_q)
		else begin fail_cnt++; $error("decoder byte differs from written byte"); end

	a_play_ready: assert property (@(posedge clk_sys) disable iff (RESET)
		playing_o |-> ready_o)
		else begin fail_cnt++; $error("playing without a tape ready"); end

endmodule

bind tape_deck_top tape_deck_assertions #(.ADDR_W(ADDR_W)) u_asrt (
	.clk_sys   (clk_sys),
	.RESET     (RESET),
	.dl_i      (dl_i),
	.wait_o    (wait_o),
	.ld_req    (wb_ld_req),
	.ld_rsp    (wb_ld_rsp),
	.pl_req    (wb_pl_req),
	.pl_rsp    (wb_pl_rsp),
	.dec_o     (dec_o),
	.playing_o (playing_o),
	.ready_o   (ready_o)
);

//--- tb_tape_deck.sv
// Tape deck testbench: host download, keys and decoder requests against a byte model
`timescale 1ns/1ps

module tb_tape_deck;

	localparam int LED_W = 10;
	localparam int TMO   = 200;

	logic                 clk_sys;
	logic                 RESET;
	host_pkg::dl_write_t  dl;
	host_pkg::key_event_t key;
	tape_pkg::dec_cmd_t   dec;
	tape_pkg::dec_rsp_t   dec_o;
	logic                 wait_o;
	logic                 playing_o;
	logic                 ready_o;
	logic                 led_o;
	logic [7:0]           model [40];
	integer               seed = 34384;
	int                   err_cnt = 0;
	int                   test_cnt = 0;
	int                   test_err;
	logic [7:0]           got;
	logic                 seen_hi;
	logic                 seen_lo;

	tape_deck_top #(.LED_W(LED_W)) u_tape_deck_top (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl_i      (dl),
		.wait_o    (wait_o),
		.key_i     (key),
		.dec_i     (dec),
		.dec_o     (dec_o),
		.playing_o (playing_o),
		.ready_o   (ready_o),
		.led_o     (led_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic check(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			$display("MISMATCH %s expected %02h actual %02h", name, exp, act);
			err_cnt++;
		end
	endtask

	// Bound assertion failures count toward the test that is running
	task automatic start_test();
		test_err = err_cnt + u_tape_deck_top.u_asrt.fail_cnt;
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		$display("%s: %s", name,
			(err_cnt + u_tape_deck_top.u_asrt.fail_cnt == test_err) ? "PASS" : "FAIL");
	endtask

	// Download a fresh tape of 40 random bytes and wait for it to be ready
	task automatic download();
		int t;
		dl.downloading = 1'b1;
		for (int i = 0; i < 40; i++) begin
			t = 0;
			while (wait_o) begin
				if (t++ > TMO)
					timeout("wait_o to fall");
				step();
			end
			model[i] = $random(seed);
			dl.wr   = 1'b1;
			dl.addr = 24'(i);
			dl.dat  = model[i];
			step();
			dl.wr = 1'b0;
		end
		t = 0;
		while (wait_o) begin
			if (t++ > TMO)
				timeout("the last write");
			step();
		end
		dl.downloading = 1'b0;
		t = 0;
		while (!ready_o) begin
			if (t++ > TMO)
				timeout("ready_o after a download");
			step();
		end
	endtask

	task automatic request_byte(output logic [7:0] val);
		int t;
		t = 0;
		dec.req = ~dec.req;
		step();
		while (dec_o.ack != dec.req) begin
			if (t++ > TMO)
				timeout("the decoder ack toggle");
			step();
		end
		val = dec_o.dat;
	endtask

	task automatic press(input logic [8:0] code);
		key.toggle  = ~key.toggle;
		key.pressed = 1'b1;
		key.code    = code;
		step();
		step();
	endtask

	initial begin
		RESET = 1'b1;
		dl    = '0;
		key   = '0;
		dec   = '0;
		repeat (10) step();
		RESET = 1'b0;

		// ==================================================
		// LED idle, no tape
		// ==================================================
		start_test();
		seen_hi = 1'b0;
		for (int i = 0; i < 2**LED_W; i++) begin
			seen_hi = seen_hi | led_o;
			step();
		end
		if (seen_hi) begin
			$display("LED lit with no tape loaded");
			err_cnt++;
		end
		end_test("led_idle");

		start_test();
		download();
		check("load_play ready", 1, ready_o);
		check("load_play playing", 1, playing_o);
		for (int i = 0; i < 40; i++) begin
			request_byte(got);
			check($sformatf("load_play byte %0d", i), model[i], got);
		end
		end_test("load_play");

		start_test();
		step();
		check("end_of_tape ready", 0, ready_o);
		check("end_of_tape playing", 0, playing_o);
		end_test("end_of_tape");

		// ==================================================
		// Keys
		// ==================================================
		start_test();
		download();
		check("keys playing after load", 1, playing_o);
		press(host_pkg::KEY_PLAY);
		check("keys F5 pause", 0, playing_o);
		press(host_pkg::KEY_PLAY);
		check("keys F5 play", 1, playing_o);
		request_byte(got);
		request_byte(got);
		press(host_pkg::KEY_REWIND);
		check("keys F6 pause", 0, playing_o);
		request_byte(got);
		check("keys F6 rewind", model[0], got);
		press(host_pkg::KEY_EJECT);
		check("keys F7 ready", 0, ready_o);
		check("keys F7 playing", 0, playing_o);
		end_test("keys");

		start_test();
		download();
		for (int i = 0; i < 3; i++)
			request_byte(got);
		dec.loop_start = 1'b1;
		step();
		dec.loop_start = 1'b0;
		request_byte(got);
		request_byte(got);
		dec.loop_next = 1'b1;
		step();
		dec.loop_next = 1'b0;
		request_byte(got);
		check("loops loop_next", model[3], got);
		end_test("loops");

		// Tape still playing here
		start_test();
		seen_hi = 1'b0;
		seen_lo = 1'b0;
		for (int i = 0; i < 2**(LED_W+1); i++) begin
			seen_hi = seen_hi | led_o;
			seen_lo = seen_lo | ~led_o;
			step();
		end
		if (!(seen_hi && seen_lo)) begin
			$display("LED did not pulse while playing");
			err_cnt++;
		end
		end_test("led_play");

		err_cnt = err_cnt + u_tape_deck_top.u_asrt.fail_cnt;
		$display("Tests run: %0d, errors: %0d, assertion failures: %0d",
			test_cnt, err_cnt, u_tape_deck_top.u_asrt.fail_cnt);
		if (err_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- tape_deck.f
tape_pkg.sv
host_pkg.sv
tape_loader.sv
tape_player.sv
tape_store.sv
tape_activity_led.sv
tape_deck_top.sv
tape_deck_assertions.sv
tb_tape_deck.sv
